/* verilog/fetch_cfg_pkg.sv */
package fetch_cfg_pkg;

    // fetch address and packet widths
    localparam int addr_w = 32;
    localparam int data_w = 64;

    // first fetch address after reset
    localparam logic [addr_w-1:0] pc_reset = 32'h1c00_0000;

    // default sizes, overridden from the top level
    localparam int btb_entries_default = 16;
    localparam int fq_depth_default    = 4;

endpackage

/* verilog/fetch_types_pkg.sv */
package fetch_types_pkg;

    // one redirect source
    typedef struct packed {
        logic                             valid;
        logic [fetch_cfg_pkg::addr_w-1:0] target;
    } redirect_t;

    // btb lookup result
    typedef struct packed {
        logic                             hit;
        logic [fetch_cfg_pkg::addr_w-1:0] target;
    } btb_pred_t;

    // resolved branch from execute
    typedef struct packed {
        logic                             valid;
        logic [fetch_cfg_pkg::addr_w-1:0] pc;
        logic                             taken;
        logic [fetch_cfg_pkg::addr_w-1:0] target;
    } btb_upd_t;

    // axi4-lite read address payload
    typedef struct packed {
        logic [fetch_cfg_pkg::addr_w-1:0] addr;
        logic [2:0]                       prot;
    } axil_ar_t;

    // axi4-lite read data payload
    typedef struct packed {
        logic [fetch_cfg_pkg::data_w-1:0] data;
        logic [1:0]                       resp;
    } axil_r_t;

    // two-instruction packet toward decode
    typedef struct packed {
        logic [fetch_cfg_pkg::addr_w-1:0] pc;
        logic [fetch_cfg_pkg::data_w-1:0] data;
        logic                             pred_taken;
        logic [fetch_cfg_pkg::addr_w-1:0] pred_target;
    } fetch_pkt_t;

endpackage

/* verilog/pc_gen.sv */
`timescale 1ns/100ps

module pc_gen (
    input  logic                             clk,
    input  logic                             rstn,
    input  fetch_types_pkg::redirect_t       redir_id,
    input  fetch_types_pkg::redirect_t       redir_ex,
    input  fetch_types_pkg::redirect_t       redir_wb,
    input  fetch_types_pkg::btb_pred_t       pred,
    input  logic                             adv,
    output logic [fetch_cfg_pkg::addr_w-1:0] pc,
    output logic                             redirect_taken
);
    import fetch_cfg_pkg::*;

    logic [addr_w-1:0] redir_target;
    logic [addr_w-1:0] seq_pc;
    logic [addr_w-1:0] next_pc;

    assign redirect_taken = redir_wb.valid | redir_ex.valid | redir_id.valid;

    // writeback is oldest, so it wins over execute, then decode
    always_comb begin
        if (redir_wb.valid) begin
            redir_target = redir_wb.target;
        end else if (redir_ex.valid) begin
            redir_target = redir_ex.target;
        end else begin
            redir_target = redir_id.target;
        end
    end

    // sequential step always lands on the next aligned packet
    assign seq_pc = {pc[addr_w-1:3], 3'b000} + addr_w'(8);

    assign next_pc = pred.hit ? pred.target : seq_pc;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= pc_reset;
        end else if (redirect_taken) begin
            pc <= redir_target;
        end else if (adv) begin
            pc <= next_pc;
        end
    end

endmodule

/* verilog/btb.sv */
`timescale 1ns/100ps

module btb #(
    parameter int btb_entries = fetch_cfg_pkg::btb_entries_default
) (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic [fetch_cfg_pkg::addr_w-1:0] lookup_pc,
    output fetch_types_pkg::btb_pred_t       pred,
    input  fetch_types_pkg::btb_upd_t        upd
);
    import fetch_cfg_pkg::*;

    localparam int idx_w = (btb_entries > 1) ? $clog2(btb_entries) : 1;
    localparam int tag_w = addr_w - 3 - idx_w;

    logic [btb_entries-1:0] valid;
    logic [tag_w-1:0]       tag_mem    [btb_entries];
    logic [addr_w-1:0]      target_mem [btb_entries];

    logic [idx_w-1:0] lk_idx;
    logic [tag_w-1:0] lk_tag;
    logic [idx_w-1:0] up_idx;
    logic [tag_w-1:0] up_tag;
    logic             up_match;

    // index from packet address, byte offset in packet ignored
    assign lk_idx = lookup_pc[3 +: idx_w];
    assign lk_tag = lookup_pc[addr_w-1 -: tag_w];
    assign up_idx = upd.pc[3 +: idx_w];
    assign up_tag = upd.pc[addr_w-1 -: tag_w];

    assign up_match = valid[up_idx] && (tag_mem[up_idx] == up_tag);

    assign pred = '{
        hit:    valid[lk_idx] && (tag_mem[lk_idx] == lk_tag),
        target: target_mem[lk_idx]
    };

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (upd.valid) begin
            if (upd.taken) begin
                valid[up_idx] <= 1'b1;
            end else if (up_match) begin
                // not taken, drop the stale prediction
                valid[up_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd.valid && upd.taken) begin
            tag_mem[up_idx]    <= up_tag;
            target_mem[up_idx] <= upd.target;
        end
    end

endmodule

/* verilog/axil_fetch_port.sv */
`timescale 1ns/100ps

module axil_fetch_port (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             issue,
    input  logic [fetch_cfg_pkg::addr_w-1:0] addr,
    output fetch_types_pkg::axil_ar_t        ar,
    output logic                             arvalid,
    input  logic                             arready,
    input  fetch_types_pkg::axil_r_t         r,
    input  logic                             rvalid,
    output logic                             rready,
    output logic                             rsp_valid,
    output logic [fetch_cfg_pkg::data_w-1:0] rsp_data,
    output logic                             busy
);
    import fetch_cfg_pkg::*;

    logic [addr_w-1:0] addr_q;
    logic              arvalid_q;
    logic              rready_q;
    logic              start;

    assign start = issue && !busy;

    // address phase, then response phase
    always_ff @(posedge clk) begin
        if (!rstn) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b0;
        end else if (start) begin
            arvalid_q <= 1'b1;
        end else if (arvalid_q && arready) begin
            arvalid_q <= 1'b0;
            rready_q  <= 1'b1;
        end else if (rready_q && rvalid) begin
            rready_q  <= 1'b0;
        end
    end

    // held stable until the ar transfer
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= {addr[addr_w-1:3], 3'b000};
        end
    end

    // prot[2] marks an instruction access
    assign ar = '{addr: addr_q, prot: 3'b100};

    assign arvalid   = arvalid_q;
    assign rready    = rready_q;
    assign busy      = arvalid_q | rready_q;
    assign rsp_valid = rready_q & rvalid;
    assign rsp_data  = r.data;

endmodule

/* verilog/fetch_queue.sv */
`timescale 1ns/100ps

module fetch_queue #(
    parameter int fq_depth = fetch_cfg_pkg::fq_depth_default
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        flush,
    input  logic                        push,
    input  fetch_types_pkg::fetch_pkt_t push_pkt,
    output fetch_types_pkg::fetch_pkt_t pkt,
    output logic                        pkt_valid,
    input  logic                        pkt_ready,
    output logic [3:0]                  free_slots
);
    import fetch_types_pkg::*;

    localparam int ptr_w = (fq_depth > 1) ? $clog2(fq_depth) : 1;
    localparam int cnt_w = $clog2(fq_depth + 1);

    fetch_pkt_t       mem [fq_depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             pop;

    assign pop        = pkt_valid && pkt_ready;
    assign pkt        = mem[rd_ptr];
    assign pkt_valid  = (count != '0);
    assign free_slots = 4'(fq_depth) - 4'(count);

    always_ff @(posedge clk) begin
        if (!rstn || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(fq_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(fq_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

endmodule

/* verilog/fetch_ctrl.sv */
`timescale 1ns/100ps

module fetch_ctrl (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             redirect_taken,
    input  logic [fetch_cfg_pkg::addr_w-1:0] pc,
    input  fetch_types_pkg::btb_pred_t       pred,
    input  logic                             busy,
    input  logic [3:0]                       free_slots,
    input  logic                             rsp_valid,
    input  logic [fetch_cfg_pkg::data_w-1:0] rsp_data,
    output logic                             issue,
    output logic                             adv,
    output logic                             flush,
    output logic                             push,
    output fetch_types_pkg::fetch_pkt_t      push_pkt
);
    import fetch_cfg_pkg::*;
    import fetch_types_pkg::*;

    logic              epoch;
    logic              issue_epoch;
    logic [addr_w-1:0] saved_pc;
    btb_pred_t         saved_pred;

    // a read in flight keeps busy high, so an idle port owes no slot
    assign issue = !busy && !redirect_taken && (free_slots != 4'd0);
    assign adv   = issue;
    assign flush = redirect_taken;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            epoch       <= 1'b0;
            issue_epoch <= 1'b0;
        end else if (redirect_taken) begin
            // forced away from the issued epoch, so repeated redirects stay stale
            epoch <= ~issue_epoch;
        end else if (issue) begin
            issue_epoch <= epoch;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            saved_pc   <= pc;
            saved_pred <= pred;
        end
    end

    // a response racing a redirect is dropped too
    assign push = rsp_valid && !redirect_taken && (issue_epoch == epoch);

    assign push_pkt = '{
        pc:          saved_pc,
        data:        rsp_data,
        pred_taken:  saved_pred.hit,
        pred_target: saved_pred.target
    };

endmodule

/* verilog/fetch_front.sv */
`timescale 1ns/100ps

module fetch_front #(
    parameter int btb_entries = fetch_cfg_pkg::btb_entries_default,
    parameter int fq_depth    = fetch_cfg_pkg::fq_depth_default
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  fetch_types_pkg::redirect_t  redir_id,
    input  fetch_types_pkg::redirect_t  redir_ex,
    input  fetch_types_pkg::redirect_t  redir_wb,
    input  fetch_types_pkg::btb_upd_t   btb_upd,
    output fetch_types_pkg::axil_ar_t   ar,
    output logic                        arvalid,
    input  logic                        arready,
    input  fetch_types_pkg::axil_r_t    r,
    input  logic                        rvalid,
    output logic                        rready,
    output fetch_types_pkg::fetch_pkt_t pkt,
    output logic                        pkt_valid,
    input  logic                        pkt_ready
);
    import fetch_cfg_pkg::*;
    import fetch_types_pkg::*;

    logic [addr_w-1:0] pc;
    logic              redirect_taken;
    btb_pred_t         pred;
    logic              issue;
    logic              adv;
    logic              flush;
    logic              busy;
    logic              rsp_valid;
    logic [data_w-1:0] rsp_data;
    logic              push;
    fetch_pkt_t        push_pkt;
    logic [3:0]        free_slots;

    pc_gen i_pc_gen (
        .clk            (clk),
        .rstn           (rstn),
        .redir_id       (redir_id),
        .redir_ex       (redir_ex),
        .redir_wb       (redir_wb),
        .pred           (pred),
        .adv            (adv),
        .pc             (pc),
        .redirect_taken (redirect_taken)
    );

    btb #(
        .btb_entries (btb_entries)
    ) i_btb (
        .clk       (clk),
        .rstn      (rstn),
        .lookup_pc (pc),
        .pred      (pred),
        .upd       (btb_upd)
    );

    axil_fetch_port i_axil_fetch_port (
        .clk       (clk),
        .rstn      (rstn),
        .issue     (issue),
        .addr      (pc),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .busy      (busy)
    );

    fetch_queue #(
        .fq_depth (fq_depth)
    ) i_fetch_queue (
        .clk        (clk),
        .rstn       (rstn),
        .flush      (flush),
        .push       (push),
        .push_pkt   (push_pkt),
        .pkt        (pkt),
        .pkt_valid  (pkt_valid),
        .pkt_ready  (pkt_ready),
        .free_slots (free_slots)
    );

    fetch_ctrl i_fetch_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .redirect_taken (redirect_taken),
        .pc             (pc),
        .pred           (pred),
        .busy           (busy),
        .free_slots     (free_slots),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .issue          (issue),
        .adv            (adv),
        .flush          (flush),
        .push           (push),
        .push_pkt       (push_pkt)
    );

endmodule

/* test/tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen (
    output logic clk,
    output logic rstn
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over two rising edges
    initial begin
        rstn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
    end

endmodule

/* test/fetch_front_asserts.sv */
`timescale 1ns/100ps

module fetch_front_asserts (
    input logic                        clk,
    input logic                        rstn,
    input fetch_types_pkg::axil_ar_t   ar,
    input logic                        arvalid,
    input logic                        arready,
    input logic                        rvalid,
    input logic                        rready,
    input fetch_types_pkg::fetch_pkt_t pkt,
    input logic                        pkt_valid,
    input logic                        pkt_ready,
    input logic                        flush
);

    int fail_count = 0;

    ar_held: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("arvalid dropped or ar changed before arready");
            fail_count++;
        end

    // a flush may empty the queue while decode stalls
    pkt_held: assert property (@(posedge clk) disable iff (!rstn)
        pkt_valid && !pkt_ready && !flush |=> pkt_valid && $stable(pkt))
        else begin
            $error("pkt changed or pkt_valid dropped while held");
            fail_count++;
        end

    r_owned: assert property (@(posedge clk) disable iff (!rstn)
        rvalid |-> rready)
        else begin
            $error("rvalid without an outstanding read");
            fail_count++;
        end

endmodule

bind fetch_front fetch_front_asserts i_fetch_front_asserts (
    .clk       (clk),
    .rstn      (rstn),
    .ar        (ar),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rready    (rready),
    .pkt       (pkt),
    .pkt_valid (pkt_valid),
    .pkt_ready (pkt_ready),
    .flush     (flush)
);

/* test/tb_fetch_front.sv */
`timescale 1ns/100ps

module tb_fetch_front;
    import fetch_cfg_pkg::*;
    import fetch_types_pkg::*;

    localparam int idx_w      = $clog2(btb_entries_default);
    localparam int tag_w      = addr_w - 3 - idx_w;
    localparam int wait_limit = 2000;

    logic       clk;
    logic       rstn;
    redirect_t  redir_id = '0;
    redirect_t  redir_ex = '0;
    redirect_t  redir_wb = '0;
    btb_upd_t   btb_upd = '0;
    axil_ar_t   ar;
    logic       arvalid;
    logic       arready = 1'b0;
    axil_r_t    r = '0;
    logic       rvalid = 1'b0;
    logic       rready;
    fetch_pkt_t pkt;
    logic       pkt_valid;
    logic       pkt_ready = 1'b1;

    integer seed = 32'h1d93_4bcb;

    // reference model state
    logic [addr_w-1:0] model_pc;
    logic              mdl_valid  [btb_entries_default];
    logic [tag_w-1:0]  mdl_tag    [btb_entries_default];
    logic [addr_w-1:0] mdl_target [btb_entries_default];

    // memory slave state
    logic              rd_pend = 1'b0;
    int                rd_delay = 0;
    logic [addr_w-1:0] rd_addr = '0;
    logic              rand_ready = 1'b0;
    logic              use_rand;

    logic              after_redir = 1'b0;
    logic [addr_w-1:0] first_pc = '0;
    logic              full_seen = 1'b0;
    int pkt_count = 0;
    int pred_count = 0;
    int errors = 0;
    int checks = 0;
    int err_mark = 0;
    int test_num = 0;
    int test_fail = 0;

    tb_clkgen i_clkgen (.clk(clk), .rstn(rstn));

    fetch_front #(
        .btb_entries (btb_entries_default),
        .fq_depth    (fq_depth_default)
    ) i_fetch_front (
        .clk       (clk),
        .rstn      (rstn),
        .redir_id  (redir_id),
        .redir_ex  (redir_ex),
        .redir_wb  (redir_wb),
        .btb_upd   (btb_upd),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .pkt       (pkt),
        .pkt_valid (pkt_valid),
        .pkt_ready (pkt_ready)
    );

    // address in the upper word, its inverse below
    function automatic logic [data_w-1:0] mem_word(input logic [addr_w-1:0] a);
        return {a, ~a};
    endfunction

    // expected packet for a fetch address
    function automatic fetch_pkt_t expect_pkt(input logic [addr_w-1:0] a);
        logic [idx_w-1:0] idx;
        fetch_pkt_t       p;
        idx = a[3 +: idx_w];
        p.pc = a;
        p.data = mem_word({a[addr_w-1:3], 3'b000});
        p.pred_taken = mdl_valid[idx] && (mdl_tag[idx] == a[addr_w-1 -: tag_w]);
        p.pred_target = mdl_target[idx];
        return p;
    endfunction

    function automatic void model_train(input btb_upd_t u);
        logic [idx_w-1:0] idx;
        idx = u.pc[3 +: idx_w];
        if (u.taken) begin
            mdl_valid[idx] = 1'b1;
            mdl_tag[idx] = u.pc[addr_w-1 -: tag_w];
            mdl_target[idx] = u.target;
        end else if (mdl_valid[idx] && mdl_tag[idx] == u.pc[addr_w-1 -: tag_w]) begin
            mdl_valid[idx] = 1'b0;
        end
    endfunction

    function automatic redirect_t redir(input logic [addr_w-1:0] a);
        return '{valid: 1'b1, target: a};
    endfunction

    task automatic check_pkt(input fetch_pkt_t got, input fetch_pkt_t exp);
        checks++;
        // target only matters for a predicted packet
        if (got.pc !== exp.pc || got.data !== exp.data || got.pred_taken !== exp.pred_taken
            || (exp.pred_taken && got.pred_target !== exp.pred_target)) begin
            errors++;
            $display("FAILED at %0t: pkt pc %h data %h pred %b/%h, expected pc %h data %h pred %b/%h",
                $time, got.pc, got.data, got.pred_taken, got.pred_target,
                exp.pc, exp.data, exp.pred_taken, exp.pred_target);
        end
    endtask

    task automatic check_addr(input logic [addr_w-1:0] got, input logic [addr_w-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // memory slave and decode ready, sampled at the edge and driven 1 ns later
    always @(posedge clk) begin
        use_rand = rand_ready;
        if (!rstn) begin
            rd_pend = 1'b0;
        end else if (arvalid && arready) begin
            rd_pend = 1'b1;
            rd_addr = ar.addr;
            rd_delay = $unsigned($random(seed)) % 4;
        end else if (rvalid && rready) begin
            rd_pend = 1'b0;
        end else if (rd_pend && rd_delay > 0) begin
            rd_delay--;
        end
        #1;
        arready = rstn && $random(seed) % 2 == 0;
        rvalid = rd_pend && rd_delay == 0;
        r = '{data: mem_word(rd_addr), resp: 2'b00};
        pkt_ready = use_rand ? (($random(seed) & 7) == 0) : 1'b1;
    end

    // compare each accepted packet, then follow training and redirects
    always @(posedge clk) begin : compare_pkts
        fetch_pkt_t exp_pkt;
        if (!rstn) begin
            model_pc = pc_reset;
            after_redir = 1'b1;
            for (int i = 0; i < btb_entries_default; i++) begin
                mdl_valid[i] = 1'b0;
            end
        end else begin
            if (i_fetch_front.free_slots == 4'd0) begin
                full_seen = 1'b1;
            end
            if (pkt_valid && pkt_ready) begin
                exp_pkt = expect_pkt(model_pc);
                check_pkt(pkt, exp_pkt);
                if (after_redir) begin
                    first_pc = pkt.pc;
                    after_redir = 1'b0;
                end
                if (pkt.pred_taken) begin
                    pred_count++;
                end
                model_pc = exp_pkt.pred_taken ? exp_pkt.pred_target
                                              : {model_pc[addr_w-1:3], 3'b000} + 8;
                pkt_count++;
            end
            if (btb_upd.valid) begin
                model_train(btb_upd);
            end
            // writeback beats execute, execute beats decode
            if (redir_wb.valid || redir_ex.valid || redir_id.valid) begin
                model_pc = redir_wb.valid ? redir_wb.target
                         : redir_ex.valid ? redir_ex.target : redir_id.target;
                after_redir = 1'b1;
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (!rstn) begin
            step();
            n++;
            if (n > 20) abort_run("reset release");
        end
    endtask

    task automatic wait_pkts(input int cnt);
        int target;
        int n;
        target = pkt_count + cnt;
        n = 0;
        while (pkt_count < target) begin
            step();
            n++;
            if (n > wait_limit) abort_run("packets");
        end
    endtask

    task automatic wait_outstanding();
        int n;
        n = 0;
        while (!rready) begin
            step();
            n++;
            if (n > wait_limit) abort_run("an outstanding read");
        end
    endtask

    // one cycle of redirects and training, starting 1 ns after an edge
    task automatic send_redirect(input redirect_t id, input redirect_t ex,
                                 input redirect_t wb, input btb_upd_t upd);
        redir_id = id;
        redir_ex = ex;
        redir_wb = wb;
        btb_upd = upd;
        step();
        redir_id = '0;
        redir_ex = '0;
        redir_wb = '0;
        btb_upd = '0;
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            test_fail++;
            $display("test %0d %s: failed with %0d errors", test_num, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        wait_reset();

        wait_pkts(8);
        check_addr(first_pc, pc_reset, "first pc after reset");
        end_test("sequential fetch after reset");

        send_redirect(redir(32'h1c00_0a00), redir(32'h1c00_0b00), redir(32'h1c00_0c05), '0);
        wait_pkts(4);
        check_addr(first_pc, 32'h1c00_0c05, "pc after wb redirect");
        send_redirect(redir(32'h1c00_0d00), redir(32'h1c00_0e03), '0, '0);
        wait_pkts(4);
        check_addr(first_pc, 32'h1c00_0e03, "pc after ex redirect");
        send_redirect(redir(32'h1c00_0f06), '0, '0, '0);
        wait_pkts(4);
        check_addr(first_pc, 32'h1c00_0f06, "pc after id redirect");
        end_test("redirect priority and realign");

        pred_count = 0;
        send_redirect('0, redir(32'h1c00_0200), '0,
                      '{valid: 1'b1, pc: 32'h1c00_0210, taken: 1'b1, target: 32'h1c00_0400});
        wait_pkts(6);
        if (pred_count != 1) begin
            errors++;
            $display("FAILED at %0t: %0d predicted packets after training, expected 1",
                $time, pred_count);
        end
        pred_count = 0;
        send_redirect('0, redir(32'h1c00_0200), '0,
                      '{valid: 1'b1, pc: 32'h1c00_0214, taken: 1'b0, target: '0});
        wait_pkts(6);
        if (pred_count != 0) begin
            errors++;
            $display("FAILED at %0t: prediction still present after not-taken update", $time);
        end
        end_test("btb install and clear");

        for (int k = 0; k < 4; k++) begin
            wait_outstanding();
            send_redirect('0, '0, redir(32'h1c00_0800 + k * 32'h100), '0);
            wait_pkts(3);
            check_addr(first_pc, 32'h1c00_0800 + k * 32'h100, "pc after mid-read redirect");
        end
        end_test("redirect drops read in flight");

        full_seen = 1'b0;
        rand_ready = 1'b1;
        wait_pkts(40);
        rand_ready = 1'b0;
        if (!full_seen) begin
            errors++;
            $display("the packet queue never filled while decode stalled");
        end
        wait_pkts(4);
        end_test("back-pressure keeps order");

        errors += i_fetch_front.i_fetch_front_asserts.fail_count;
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
            test_num, test_fail, checks, errors);
        if (errors == 0 && test_fail == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* fetch_front.f */
verilog/fetch_cfg_pkg.sv
verilog/fetch_types_pkg.sv
verilog/pc_gen.sv
verilog/btb.sv
verilog/axil_fetch_port.sv
verilog/fetch_queue.sv
verilog/fetch_ctrl.sv
verilog/fetch_front.sv
test/tb_clkgen.sv
test/fetch_front_asserts.sv
test/tb_fetch_front.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_front \
    -f fetch_front.f \
    -o sim_fetch_front

out=$(./obj_dir/sim_fetch_front 2>&1 || true)
echo "$out"

if echo "$out" | grep -qx "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
